// File: logic/audio_dac_cfg.svh
/* Frame timing and pulse field widths for the stereo PWM audio DAC */
`ifndef AUDIO_DAC_CFG_SVH
`define AUDIO_DAC_CFG_SVH

// sys_clk cycles per output frame
// Must exceed reload plus wrap, so 130 at least
`define AUDIO_DAC_FRAME_CYCLES 160

// Phase counter load value at frame start
`define AUDIO_DAC_PHASE_RELOAD 128

// Width of one pulse field, coarse and fine alike
`define AUDIO_DAC_WIDTH_BITS 7

// Host sample word
`define AUDIO_DAC_SAMPLE_BITS 16

`endif

// File: logic/audio_dac_pkg.sv
/* Sample union, channel pair and phase types shared by the DAC blocks */
`default_nettype none
`include "audio_dac_cfg.svh"

package audio_dac_pkg;

	// Field view of one sample word
	// Coarse carries six magnitude bits, the sign completes it to seven
	typedef struct packed {
		logic                           sign;
		logic [`AUDIO_DAC_WIDTH_BITS-2:0] coarse;
		logic [`AUDIO_DAC_WIDTH_BITS-1:0] fine;
		logic [1:0]                     unused;
	} dac_field_t;

	// Same 16 bits seen as host word or as pulse fields
	typedef union packed {
		logic signed [`AUDIO_DAC_SAMPLE_BITS-1:0] raw;
		dac_field_t                               field;
	} dac_sample_u;

	// Left and right sample travelling together
	typedef struct packed {
		dac_sample_u left;
		dac_sample_u right;
	} dac_pair_t;

	// Phase seen by every pulse generator
	typedef struct packed {
		logic [7:0] count;
		logic       running;
	} phase_t;

endpackage

`default_nettype wire

// File: logic/frame_timer.sv
/* Frame timer, a modulo counter that pulses frame_start once per frame */
`timescale 1ns/1ps
`default_nettype none
`include "audio_dac_cfg.svh"

module frame_timer (
	input  logic sys_clk,
	input  logic resetl,
	output logic frame_start
);

	localparam int CNT_BITS = $clog2(`AUDIO_DAC_FRAME_CYCLES);
	localparam logic [CNT_BITS-1:0] CNT_TERM = CNT_BITS'(`AUDIO_DAC_FRAME_CYCLES - 1);

	// Cycle position within the current frame
	logic [CNT_BITS-1:0] cycle_cnt;
	logic                at_term;

	// Last cycle of the frame
	assign at_term = (cycle_cnt == CNT_TERM);

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			cycle_cnt <= '0;
			frame_start <= 1'b0;
		end else begin
			// Wrap on terminal count and flag the new frame
			if (at_term) begin
				cycle_cnt <= '0;
			end else begin
				cycle_cnt <= cycle_cnt + 1'b1;
			end
			// Registered so the pulse is one clean cycle wide
			frame_start <= at_term;
		end
	end

endmodule

`default_nettype wire

// File: logic/sample_latch.sv
/* Double-buffered sample registers
   Host writes land in holding registers, frame_start moves them to the output */
`timescale 1ns/1ps
`default_nettype none

module sample_latch (
	input  logic                      sys_clk,
	input  logic                      resetl,
	input  logic                      left_wr,
	input  logic                      right_wr,
	input  audio_dac_pkg::dac_sample_u sample_data,
	input  logic                      frame_start,
	output audio_dac_pkg::dac_pair_t   out_pair
);

	// Samples written by the host since the last frame
	audio_dac_pkg::dac_pair_t hold_pair;

	// Holding stage
	// Both strobes together load the same word into both channels
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			hold_pair <= '0;
		end else begin
			if (left_wr) begin
				hold_pair.left <= sample_data;
			end
			if (right_wr) begin
				hold_pair.right <= sample_data;
			end
		end
	end

	// Output stage
	// Takes the old holding value, a write in the frame_start cycle waits a frame
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			out_pair <= '0;
		end else if (frame_start) begin
			out_pair <= hold_pair;
		end
	end

endmodule

`default_nettype wire

// File: logic/pwm_phase_counter.sv
/* Phase down-counter, reloaded on frame_start and stopped after it wraps */
`timescale 1ns/1ps
`default_nettype none
`include "audio_dac_cfg.svh"

module pwm_phase_counter (
	input  logic                  sys_clk,
	input  logic                  resetl,
	input  logic                  frame_start,
	output audio_dac_pkg::phase_t phase
);

	logic [7:0] count_dec;
	logic       stop_next;

	// Next count while running
	assign count_dec = phase.count - 8'd1;

	// Bits 7 and 6 both set only after the wrap from 0 to 255
	assign stop_next = count_dec[7] & count_dec[6];

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			phase.count <= 8'd0;
			phase.running <= 1'b0;
		end else if (frame_start) begin
			// New frame, start the sweep from the top
			phase.count <= 8'(`AUDIO_DAC_PHASE_RELOAD);
			phase.running <= 1'b1;
		end else if (phase.running) begin
			phase.count <= count_dec;
			// Running is the inverse of the stop condition
			phase.running <= ~stop_next;
		end
		// Otherwise hold at 255 until the next frame
	end

endmodule

`default_nettype wire

// File: logic/pwm_pulse.sv
/* Single pulse generator
   Compares the running phase against a 7-bit width, registered output */
`timescale 1ns/1ps
`default_nettype none
`include "audio_dac_cfg.svh"

module pwm_pulse (
	input  logic                             sys_clk,
	input  logic                             resetl,
	input  audio_dac_pkg::phase_t            phase,
	input  logic [`AUDIO_DAC_WIDTH_BITS-1:0] width,
	output logic                             pulse
);

	logic in_window;
	logic count_nonzero;
	logic count_le_width;

	// Count 0 is the last running cycle, never part of the pulse
	assign count_nonzero = (phase.count != 8'd0);

	// Width zero-extended to the counter size
	// Tops out at 127, so the reload count 128 never falls inside
	assign count_le_width = (phase.count <= {1'b0, width});

	// Counts width down to 1, so exactly width cycles per frame
	assign in_window = phase.running & count_nonzero & count_le_width;

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			pulse <= 1'b0;
		end else begin
			pulse <= in_window;
		end
	end

endmodule

`default_nettype wire

// File: logic/audio_dac.sv
/* Stereo PWM audio DAC top level
   Frame timer, sample latch, phase counter and four pulse generators */
`timescale 1ns/1ps
`default_nettype none
`include "audio_dac_cfg.svh"

module audio_dac (
	input  logic                      sys_clk,
	input  logic                      resetl,
	input  logic                      left_wr,
	input  logic                      right_wr,
	input  audio_dac_pkg::dac_sample_u sample_data,
	output logic [1:0]                ldac,
	output logic [1:0]                rdac
);

	logic                     frame_start;
	audio_dac_pkg::dac_pair_t out_pair;
	audio_dac_pkg::phase_t    phase;

	// Per-channel pulse widths
	logic [`AUDIO_DAC_WIDTH_BITS-1:0] left_coarse;
	logic [`AUDIO_DAC_WIDTH_BITS-1:0] left_fine;
	logic [`AUDIO_DAC_WIDTH_BITS-1:0] right_coarse;
	logic [`AUDIO_DAC_WIDTH_BITS-1:0] right_fine;

	// Coarse is offset binary, inverted sign on top of bits 14..9
	assign left_coarse = {~out_pair.left.field.sign, out_pair.left.field.coarse};
	assign right_coarse = {~out_pair.right.field.sign, out_pair.right.field.coarse};

	// Fine is bits 8..2 as they stand
	assign left_fine = out_pair.left.field.fine;
	assign right_fine = out_pair.right.field.fine;

	// Sets the output sample rate
	frame_timer frame_timer_inst (
		.sys_clk     (sys_clk),
		.resetl      (resetl),
		.frame_start (frame_start)
	);

	sample_latch sample_latch_inst (
		.sys_clk     (sys_clk),
		.resetl      (resetl),
		.left_wr     (left_wr),
		.right_wr    (right_wr),
		.sample_data (sample_data),
		.frame_start (frame_start),
		.out_pair    (out_pair)
	);

	// One phase sweep shared by all four outputs
	pwm_phase_counter phase_counter_inst (
		.sys_clk     (sys_clk),
		.resetl      (resetl),
		.frame_start (frame_start),
		.phase       (phase)
	);

	// Bit 0 fine, bit 1 coarse
	pwm_pulse ldac_fine_inst (
		.sys_clk (sys_clk),
		.resetl  (resetl),
		.phase   (phase),
		.width   (left_fine),
		.pulse   (ldac[0])
	);

	pwm_pulse ldac_coarse_inst (
		.sys_clk (sys_clk),
		.resetl  (resetl),
		.phase   (phase),
		.width   (left_coarse),
		.pulse   (ldac[1])
	);

	pwm_pulse rdac_fine_inst (
		.sys_clk (sys_clk),
		.resetl  (resetl),
		.phase   (phase),
		.width   (right_fine),
		.pulse   (rdac[0])
	);

	pwm_pulse rdac_coarse_inst (
		.sys_clk (sys_clk),
		.resetl  (resetl),
		.phase   (phase),
		.width   (right_coarse),
		.pulse   (rdac[1])
	);

endmodule

`default_nettype wire

// File: bench/audio_dac_assert.sv
/* Concurrent checks on frame pulse, phase sweep and output pulses
   Bound into the DAC top level */
`timescale 1ns/1ps
`default_nettype none

module audio_dac_assert (
	input logic                  sys_clk,
	input logic                  resetl,
	input logic                  frame_start,
	input audio_dac_pkg::phase_t phase,
	input logic [1:0]            ldac,
	input logic [1:0]            rdac
);

	// All four outputs, same order as {rdac, ldac}
	logic [3:0] outs;
	logic [3:0] outs_q;
	logic [3:0] rise;
	// Outputs that already rose in the current frame
	logic [3:0] rose_seen;

	// Read by the testbench at the end of the run
	int unsigned fail_count = 0;

	assign outs = {rdac, ldac};
	assign rise = outs & ~outs_q;

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			outs_q <= '0;
			rose_seen <= '0;
		end else begin
			outs_q <= outs;
			// New frame clears the edge record
			if (frame_start) begin
				rose_seen <= '0;
			end else begin
				rose_seen <= rose_seen | rise;
			end
		end
	end

	// Pulses only while the phase sweep runs
	idle_outputs_low: assert property (@(posedge sys_clk) disable iff (!resetl)
		!phase.running |-> (outs == 4'b0))
	else begin
		fail_count++;
		$error("DAC output high while the phase counter is stopped");
	end

	frame_start_single: assert property (@(posedge sys_clk) disable iff (!resetl)
		frame_start |=> !frame_start)
	else begin
		fail_count++;
		$error("frame_start stayed high for more than one cycle");
	end

	// Sweep moves every cycle
	count_moves: assert property (@(posedge sys_clk) disable iff (!resetl)
		(phase.running && !frame_start) |=> (phase.count != $past(phase.count)))
	else begin
		fail_count++;
		$error("Phase count held while running");
	end

	one_rise_per_frame: assert property (@(posedge sys_clk) disable iff (!resetl)
		(rise & rose_seen) == 4'b0)
	else begin
		fail_count++;
		$error("DAC output rose twice within one frame");
	end

endmodule

bind audio_dac audio_dac_assert audio_dac_assert_inst (
	.sys_clk     (sys_clk),
	.resetl      (resetl),
	.frame_start (frame_start),
	.phase       (phase),
	.ldac        (ldac),
	.rdac        (rdac)
);

`default_nettype wire

// File: bench/audio_dac_tb.sv
/* Testbench for the stereo PWM audio DAC
   Clock, reset, sample stimulus, per-frame pulse measurement and watchdog */
`timescale 1ns/1ps
`default_nettype none
`include "audio_dac_cfg.svh"

module audio_dac_tb;

	localparam int CLK_HALF_NS = 2;
	localparam int FRAME_CYCLES = `AUDIO_DAC_FRAME_CYCLES;
	// Measured frames, each preceded by one alignment frame
	localparam int FRAME_CHECKS = 30;
	localparam int FRAMES_PER_CHECK = 2;
	localparam int WATCHDOG_NS = (FRAME_CHECKS * FRAMES_PER_CHECK + 4) * FRAME_CYCLES * 4;

	logic                       sys_clk;
	logic                       resetl;
	logic                       left_wr;
	logic                       right_wr;
	audio_dac_pkg::dac_sample_u sample_data;
	logic [1:0]                 ldac;
	logic [1:0]                 rdac;

	// Per-test bookkeeping
	string test_name;
	int    test_errs;
	int    tests_passed;
	int    tests_failed;

	// High cycles per output in the last measured frame
	// Index 0 ldac fine, 1 ldac coarse, 2 rdac fine, 3 rdac coarse
	int meas_len [4];

	audio_dac audio_dac_inst (
		.sys_clk     (sys_clk),
		.resetl      (resetl),
		.left_wr     (left_wr),
		.right_wr    (right_wr),
		.sample_data (sample_data),
		.ldac        (ldac),
		.rdac        (rdac)
	);

	initial begin
		sys_clk = 1'b0;
		forever #CLK_HALF_NS sys_clk = ~sys_clk;
	end

	initial begin
		#WATCHDOG_NS;
		$display("Timeout, the run did not finish within %0d ns", WATCHDOG_NS);
		$display("TEST FAILED");
		$finish;
	end

	// Signed word shifted to offset binary, top seven of its 16 bits
	function automatic int coarse_width(input logic [15:0] word);
		int offset;
		offset = int'($signed(word)) + 32768;
		return offset / 512;
	endfunction

	// Next seven bits below the coarse field, last two bits dropped
	function automatic int fine_width(input logic [15:0] word);
		return (int'(word) / 4) % 128;
	endfunction

	function automatic string output_name(input int idx);
		case (idx)
			0: return "ldac_fine";
			1: return "ldac_coarse";
			2: return "rdac_fine";
			default: return "rdac_coarse";
		endcase
	endfunction

	task automatic begin_test(input string name);
		test_name = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		if (test_errs == 0) begin
			tests_passed++;
			$display("%s: ok", test_name);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", test_name, test_errs);
		end
	endtask

	// One-cycle strobe, driven just after the clock edge
	task automatic write_sample(input logic wr_l, input logic wr_r, input logic [15:0] word);
		@(posedge sys_clk);
		#1;
		left_wr = wr_l;
		right_wr = wr_r;
		sample_data.raw = word;
		@(posedge sys_clk);
		#1;
		left_wr = 1'b0;
		right_wr = 1'b0;
	endtask

	// Returns at the falling edge inside the next frame_start cycle
	task automatic wait_frame_start();
		do begin
			@(negedge sys_clk);
		end while (!audio_dac_inst.frame_start);
	endtask

	// Counts high cycles on each output up to the following frame_start
	task automatic measure_frame();
		logic [3:0] outs;
		for (int i = 0; i < 4; i++) begin
			meas_len[i] = 0;
		end
		wait_frame_start();
		repeat (FRAME_CYCLES - 1) begin
			@(negedge sys_clk);
			outs = {rdac, ldac};
			for (int i = 0; i < 4; i++) begin
				if (outs[i]) begin
					meas_len[i]++;
				end
			end
		end
	endtask

	// Measures the next frame against the widths of two sample words
	task automatic check_frame(input logic [15:0] left_word, input logic [15:0] right_word);
		int exp_len [4];
		exp_len[0] = fine_width(left_word);
		exp_len[1] = coarse_width(left_word);
		exp_len[2] = fine_width(right_word);
		exp_len[3] = coarse_width(right_word);
		measure_frame();
		for (int i = 0; i < 4; i++) begin
			assert (meas_len[i] == exp_len[i]) else begin
				test_errs++;
				$display("FAIL %s %s expected %0d actual %0d", test_name, output_name(i),
					exp_len[i], meas_len[i]);
			end
		end
	endtask

	// Loads both channels early in a frame and checks the frame after it
	task automatic load_and_check(input logic [15:0] left_word, input logic [15:0] right_word);
		wait_frame_start();
		write_sample(1'b1, 1'b0, left_word);
		write_sample(1'b0, 1'b1, right_word);
		check_frame(left_word, right_word);
	endtask

	initial begin
		logic [15:0] rand_l;
		logic [15:0] rand_r;
		void'($urandom(89350));
		resetl = 1'b0;
		left_wr = 1'b0;
		right_wr = 1'b0;
		sample_data = '0;
		tests_passed = 0;
		tests_failed = 0;
		repeat (4) @(posedge sys_clk);
		#1;
		resetl = 1'b1;

		// Quiet until the first frame_start
		begin_test("reset");
		do begin
			@(negedge sys_clk);
			assert (({rdac, ldac} == 4'b0) && !audio_dac_inst.phase.running) else begin
				test_errs++;
				$display("FAIL reset expected outputs 0000 running 0 actual outputs %b running %b",
					{rdac, ldac}, audio_dac_inst.phase.running);
			end
		end while (!audio_dac_inst.frame_start);
		end_test();

		// Full scale, negative full scale and midscale, channels crossed
		begin_test("width_map");
		load_and_check(16'h7FFC, 16'h8000);
		load_and_check(16'h8000, 16'h0000);
		load_and_check(16'h0000, 16'h7FFC);
		end_test();

		begin_test("random");
		repeat (20) begin
			rand_l = 16'($urandom());
			rand_r = 16'($urandom());
			load_and_check(rand_l, rand_r);
		end
		end_test();

		// Mid-frame write held back a frame
		begin_test("double_buffer");
		wait_frame_start();
		write_sample(1'b1, 1'b0, 16'h4A5C);
		write_sample(1'b0, 1'b1, 16'hB3A8);
		fork
			check_frame(16'h4A5C, 16'hB3A8);
			begin
				wait_frame_start();
				repeat (40) @(posedge sys_clk);
				write_sample(1'b1, 1'b0, 16'h2468);
				write_sample(1'b0, 1'b1, 16'hE1F4);
			end
		join
		// Strobe inside the frame_start cycle itself
		fork
			check_frame(16'h2468, 16'hE1F4);
			begin
				@(posedge sys_clk);
				#1;
				left_wr = 1'b1;
				right_wr = 1'b1;
				sample_data.raw = 16'h5F0C;
				assert (audio_dac_inst.frame_start) else begin
					test_errs++;
					$display("Write strobe did not fall in the frame_start cycle");
				end
				@(posedge sys_clk);
				#1;
				left_wr = 1'b0;
				right_wr = 1'b0;
			end
		join
		check_frame(16'h5F0C, 16'h5F0C);
		end_test();

		// Right keeps its last word, then both strobes share one word
		begin_test("strobe_indep");
		wait_frame_start();
		write_sample(1'b1, 1'b0, 16'h9C40);
		check_frame(16'h9C40, 16'h5F0C);
		wait_frame_start();
		write_sample(1'b1, 1'b1, 16'h3E7B);
		check_frame(16'h3E7B, 16'h3E7B);
		end_test();

		begin_test("reset_in_op");
		wait_frame_start();
		write_sample(1'b1, 1'b1, 16'h7FFC);
		wait_frame_start();
		// Well inside the sweep, all four pulses high
		repeat (100) @(posedge sys_clk);
		@(negedge sys_clk);
		assert ({rdac, ldac} == 4'b1111) else begin
			test_errs++;
			$display("FAIL reset_in_op expected outputs 1111 actual %b", {rdac, ldac});
		end
		@(posedge sys_clk);
		#1;
		resetl = 1'b0;
		@(posedge sys_clk);
		@(negedge sys_clk);
		assert (({rdac, ldac} == 4'b0) && !audio_dac_inst.phase.running) else begin
			test_errs++;
			$display("FAIL reset_in_op expected outputs 0000 running 0 actual outputs %b running %b",
				{rdac, ldac}, audio_dac_inst.phase.running);
		end
		repeat (3) @(posedge sys_clk);
		#1;
		resetl = 1'b1;
		// Held samples cleared, so midscale on both channels
		check_frame(16'h0000, 16'h0000);
		end_test();

		if (audio_dac_inst.audio_dac_assert_inst.fail_count != 0) begin
			$display("Bound assertions failed %0d times",
				audio_dac_inst.audio_dac_assert_inst.fail_count);
			tests_failed++;
		end
		$display("Tests passed %0d, failed %0d", tests_passed, tests_failed);
		if (tests_failed == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+logic
logic/audio_dac_pkg.sv
logic/frame_timer.sv
logic/sample_latch.sv
logic/pwm_phase_counter.sv
logic/pwm_pulse.sv
logic/audio_dac.sv
bench/audio_dac_assert.sv
bench/audio_dac_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the audio DAC testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=audio_dac_sim

rm -rf obj_dir
if [ $? -ne 0 ]; then
	echo "could not clean obj_dir"
	exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
	-f src.f --top-module audio_dac_tb -o "$BIN"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

# Error limit raised so bound assertion failures reach the end of the run
./obj_dir/"$BIN" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
	exit 1
fi
exit 0
